//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_gnn_layer
RTL_TOP   ?= gnn_layer_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

SRCS := $(wildcard src/*.sv include/*.svh testbench/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+include
src/gnn_pkg.sv
src/graph_store.sv
src/layer_sequencer.sv
src/spmm_engine.sv
src/output_stage.sv
src/debug_monitor.sv
src/gnn_layer_top.sv
testbench/tb_gnn_layer.sv

//--- include/gnn_settings.svh
`ifndef GNN_SETTINGS_SVH
`define GNN_SETTINGS_SVH

// node memory and node index
`define GNN_NODE_AW 4
`define GNN_NODES 16

// sparse entry memory
`define GNN_SP_AW 8
`define GNN_MAX_NNZ 12

// first output address, node 0 lands here.
`define GNN_OUT_BASE 8'h20

// outputs at or above this address are reserved.
`define GNN_DBG_ADDR_LIMIT 8'h2C

// nodes whose raw sums the debug monitor keeps.
`define GNN_DBG_CAPTURE_A 3
`define GNN_DBG_CAPTURE_B 10

`endif

//--- src/debug_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "gnn_settings.svh"

module debug_monitor
  import gnn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        spmm_start_i,
  input  logic        spmm_done_i,
  input  logic        out_start_i,
  input  logic        out_done_i,
  input  node_idx_t   node_idx_i,
  input  acc_t        result_i,
  input  logic        out_we_i,
  input  out_wr_t     out_wr_i,
  output dbg_status_t status_o,
  output logic [31:0] count_o,
  output acc_t        capture_a_o,
  output acc_t        capture_b_o
);

  dbg_status_t status_q;
  logic [31:0] count_q;
  acc_t        cap_a_q;
  acc_t        cap_b_q;
  logic        reserved_hit;
  logic        hit_a;
  logic        hit_b;

  assign reserved_hit = out_we_i && (out_wr_i.addr >= out_addr_t'(`GNN_DBG_ADDR_LIMIT));
  assign hit_a = spmm_done_i && (node_idx_i == node_idx_t'(`GNN_DBG_CAPTURE_A));
  assign hit_b = spmm_done_i && (node_idx_i == node_idx_t'(`GNN_DBG_CAPTURE_B));

  // flags only ever set, reset is the sole way back.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      status_q.spmm_start_seen    <= status_q.spmm_start_seen | spmm_start_i;
      status_q.spmm_done_seen     <= status_q.spmm_done_seen | spmm_done_i;
      status_q.out_start_seen     <= status_q.out_start_seen | out_start_i;
      status_q.out_done_seen      <= status_q.out_done_seen | out_done_i;
      status_q.out_write_seen     <= status_q.out_write_seen | out_we_i;
      status_q.reserved_addr_seen <= status_q.reserved_addr_seen | reserved_hit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else begin
      if (spmm_done_i) begin
        count_q <= count_q + 32'd1;  // nodes finished since reset.
      end
      if (hit_a) begin
        cap_a_q <= result_i;
      end
      if (hit_b) begin
        cap_b_q <= result_i;
      end
    end
  end

  assign status_o    = status_q;
  assign count_o     = count_q;
  assign capture_a_o = cap_a_q;
  assign capture_b_o = cap_b_q;

endmodule

`default_nettype wire

//--- src/gnn_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module gnn_layer_top
  import gnn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        host_we_i,
  input  host_wr_t    host_wr_i,
  input  logic        run_i,
  input  node_idx_t   run_nodes_i,
  output logic        busy_o,
  output logic        done_o,
  output logic        out_we_o,
  output out_wr_t     out_wr_o,
  output dbg_status_t debug_status_o,
  output logic [31:0] debug_count_o,
  output acc_t        debug_capture_a_o,
  output acc_t        debug_capture_b_o
);

  logic       spmm_start;
  logic       spmm_done;
  logic       out_start;
  logic       out_done;
  node_idx_t  node_idx;
  acc_t       spmm_result;
  node_idx_t  info_addr;
  sp_addr_t   sp_addr;
  node_idx_t  feat_addr;
  node_info_t info_rd;
  sp_entry_t  sp_rd;
  feat_t      feat_rd;

  graph_store i_graph_store (
    .clk(clk), .rst_n(rst_n), .host_we_i(host_we_i), .host_wr_i(host_wr_i),
    .info_addr_i(info_addr), .sp_addr_i(sp_addr), .feat_addr_i(feat_addr),
    .info_o(info_rd), .sp_o(sp_rd), .feat_o(feat_rd)
  );

  layer_sequencer i_layer_sequencer (
    .clk(clk), .rst_n(rst_n), .run_i(run_i), .run_nodes_i(run_nodes_i),
    .spmm_done_i(spmm_done), .out_done_i(out_done), .spmm_start_o(spmm_start),
    .out_start_o(out_start), .node_idx_o(node_idx), .busy_o(busy_o), .done_o(done_o)
  );

  spmm_engine i_spmm_engine (
    .clk(clk), .rst_n(rst_n), .start_i(spmm_start), .node_idx_i(node_idx),
    .info_addr_o(info_addr), .info_i(info_rd), .sp_addr_o(sp_addr), .sp_i(sp_rd),
    .feat_addr_o(feat_addr), .feat_i(feat_rd), .done_o(spmm_done), .result_o(spmm_result)
  );

  output_stage i_output_stage (
    .clk(clk), .rst_n(rst_n), .start_i(out_start), .node_idx_i(node_idx),
    .result_i(spmm_result), .out_we_o(out_we_o), .out_wr_o(out_wr_o), .done_o(out_done)
  );

  debug_monitor i_debug_monitor (
    .clk(clk), .rst_n(rst_n), .spmm_start_i(spmm_start), .spmm_done_i(spmm_done),
    .out_start_i(out_start), .out_done_i(out_done), .node_idx_i(node_idx),
    .result_i(spmm_result), .out_we_i(out_we_o), .out_wr_i(out_wr_o),
    .status_o(debug_status_o), .count_o(debug_count_o),
    .capture_a_o(debug_capture_a_o), .capture_b_o(debug_capture_b_o)
  );

endmodule

`default_nettype wire

//--- src/gnn_pkg.sv
`default_nettype none

`include "gnn_settings.svh"

package gnn_pkg;

  typedef logic [`GNN_NODE_AW-1:0] node_idx_t;
  typedef logic [`GNN_SP_AW-1:0]   sp_addr_t;
  typedef logic [3:0]              nnz_t;
  typedef logic signed [15:0]      feat_t;
  typedef logic signed [31:0]      acc_t;
  typedef logic [7:0]              out_addr_t;

  typedef struct packed {
    sp_addr_t base;  // first sparse entry of the row.
    nnz_t     nnz;
  } node_info_t;

  typedef struct packed {
    node_idx_t col;
    feat_t     value;
  } sp_entry_t;

  typedef enum logic [1:0] {
    MEM_INFO,
    MEM_SPARSE,
    MEM_FEAT
  } mem_sel_e;

  typedef struct packed {
    mem_sel_e    sel;
    logic [7:0]  addr;
    logic [31:0] data;  // low bits used per memory.
  } host_wr_t;

  typedef struct packed {
    out_addr_t addr;
    feat_t     data;
  } out_wr_t;

  typedef struct packed {
    logic spmm_start_seen;
    logic spmm_done_seen;
    logic out_start_seen;
    logic out_done_seen;
    logic out_write_seen;
    logic reserved_addr_seen;
  } dbg_status_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_SPMM,
    WAIT_OUT
  } seq_state_e;

endpackage

`default_nettype wire

//--- src/graph_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "gnn_settings.svh"

module graph_store
  import gnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       host_we_i,
  input  host_wr_t   host_wr_i,
  input  node_idx_t  info_addr_i,
  input  sp_addr_t   sp_addr_i,
  input  node_idx_t  feat_addr_i,
  output node_info_t info_o,
  output sp_entry_t  sp_o,
  output feat_t      feat_o
);

  node_info_t info_mem [`GNN_NODES];
  sp_entry_t  sp_mem   [2**`GNN_SP_AW];
  feat_t      feat_mem [`GNN_NODES];

  node_idx_t  wr_node;
  sp_addr_t   wr_sp;

  assign wr_node = host_wr_i.addr[`GNN_NODE_AW-1:0];
  assign wr_sp   = host_wr_i.addr[`GNN_SP_AW-1:0];

  // host side, one word per strobe.
  always_ff @(posedge clk) begin
    if (host_we_i) begin
      unique case (host_wr_i.sel)
        MEM_INFO:   info_mem[wr_node] <= node_info_t'(host_wr_i.data[$bits(node_info_t)-1:0]);
        MEM_SPARSE: sp_mem[wr_sp]     <= sp_entry_t'(host_wr_i.data[$bits(sp_entry_t)-1:0]);
        MEM_FEAT:   feat_mem[wr_node] <= feat_t'(host_wr_i.data[$bits(feat_t)-1:0]);
        default: ;
      endcase
    end
  end

  // read ports, one cycle latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      info_o <= '0;
      sp_o   <= '0;
      feat_o <= '0;
    end else begin
      info_o <= info_mem[info_addr_i];
      sp_o   <= sp_mem[sp_addr_i];
      feat_o <= feat_mem[feat_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- src/layer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer
  import gnn_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      run_i,
  input  node_idx_t run_nodes_i,
  input  logic      spmm_done_i,
  input  logic      out_done_i,
  output logic      spmm_start_o,
  output logic      out_start_o,
  output node_idx_t node_idx_o,
  output logic      busy_o,
  output logic      done_o
);

  seq_state_e state_q;
  node_idx_t  last_q;  // index of the final node, N-1.
  node_idx_t  idx_q;
  logic       out_start_q;
  logic       done_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      last_q      <= '0;
      idx_q       <= '0;
      out_start_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      out_start_q <= 1'b0;
      done_q      <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (run_i) begin
            last_q  <= run_nodes_i;
            idx_q   <= '0;
            state_q <= ISSUE;
          end
        end
        ISSUE: begin
          state_q <= WAIT_SPMM;
        end
        WAIT_SPMM: begin
          if (spmm_done_i) begin
            out_start_q <= 1'b1;
            state_q     <= WAIT_OUT;
          end
        end
        WAIT_OUT: begin
          if (out_done_i) begin
            if (idx_q == last_q) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= ISSUE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // spmm start is decoded so it follows out_done by one cycle.
  assign spmm_start_o = (state_q == ISSUE);
  assign out_start_o  = out_start_q;
  assign node_idx_o   = idx_q;
  assign busy_o       = (state_q != IDLE);
  assign done_o       = done_q;

endmodule

`default_nettype wire

//--- src/output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "gnn_settings.svh"

module output_stage
  import gnn_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start_i,
  input  node_idx_t node_idx_i,
  input  acc_t      result_i,
  output logic      out_we_o,
  output out_wr_t   out_wr_o,
  output logic      done_o
);

  localparam acc_t SAT_MAX = 32'sd32767;

  feat_t     sat_data;
  out_addr_t wr_addr;
  logic      we_q;
  logic      done_q;
  out_wr_t   wr_q;

  // relu, then clip to the positive 16 bit range.
  always_comb begin
    if (result_i < 0) begin
      sat_data = '0;
    end else if (result_i > SAT_MAX) begin
      sat_data = feat_t'(SAT_MAX[15:0]);
    end else begin
      sat_data = feat_t'(result_i[15:0]);
    end
  end

  assign wr_addr = out_addr_t'(`GNN_OUT_BASE) + out_addr_t'(node_idx_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      we_q   <= start_i;
      done_q <= start_i;  // write and done leave together.
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      wr_q.addr <= wr_addr;
      wr_q.data <= sat_data;
    end
  end

  assign out_we_o = we_q;
  assign out_wr_o = wr_q;
  assign done_o   = done_q;

endmodule

`default_nettype wire

//--- src/spmm_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spmm_engine
  import gnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start_i,
  input  node_idx_t  node_idx_i,
  output node_idx_t  info_addr_o,
  input  node_info_t info_i,
  output sp_addr_t   sp_addr_o,
  input  sp_entry_t  sp_i,
  output node_idx_t  feat_addr_o,
  input  feat_t      feat_i,
  output logic       done_o,
  output acc_t       result_o
);

  logic     info_pend_q;  // node info valid this cycle.
  sp_addr_t ptr_q;
  nnz_t     remain_q;     // entries still to issue.
  logic     issue_v;
  logic     issue_last;
  logic     row_empty;

  logic     fetch_v_q;
  logic     fetch_last_q;
  logic     mac_v_q;
  logic     mac_last_q;
  feat_t    value_q;
  acc_t     product;
  acc_t     acc_q;
  logic     done_q;

  assign info_addr_o = node_idx_i;
  assign issue_v     = (remain_q != '0);
  assign issue_last  = (remain_q == nnz_t'(1));
  assign row_empty   = info_pend_q && (info_i.nnz == '0);
  assign sp_addr_o   = ptr_q;
  assign feat_addr_o = sp_i.col;  // column picks the feature.
  assign product     = value_q * feat_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      info_pend_q  <= 1'b0;
      ptr_q        <= '0;
      remain_q     <= '0;
      fetch_v_q    <= 1'b0;
      fetch_last_q <= 1'b0;
      mac_v_q      <= 1'b0;
      mac_last_q   <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      info_pend_q <= start_i;
      if (info_pend_q) begin
        ptr_q    <= info_i.base;
        remain_q <= info_i.nnz;
      end else if (issue_v) begin
        ptr_q    <= ptr_q + 1'b1;
        remain_q <= remain_q - 1'b1;
      end
      // an empty row sends only the tail marker down the pipe.
      fetch_v_q    <= issue_v;
      fetch_last_q <= (issue_v && issue_last) || row_empty;
      mac_v_q      <= fetch_v_q;
      mac_last_q   <= fetch_last_q;
      done_q       <= mac_last_q;
    end
  end

  always_ff @(posedge clk) begin
    value_q <= sp_i.value;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (start_i) begin
      acc_q <= '0;
    end else if (mac_v_q) begin
      acc_q <= acc_q + product;
    end
  end

  assign done_o   = done_q;
  assign result_o = acc_q;

endmodule

`default_nettype wire

//--- testbench/tb_gnn_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gnn_settings.svh"

module tb_gnn_layer
  import gnn_pkg::*;
();

  localparam int CLK_NS      = 20;
  localparam int NUM_TESTS   = 5;
  localparam int NODE_CYCLES = `GNN_MAX_NNZ + 8;
  localparam int LOAD_CYCLES = 2 * `GNN_NODES + 2**`GNN_SP_AW;
  localparam int WATCHDOG_NS = NUM_TESTS * (`GNN_NODES * NODE_CYCLES + LOAD_CYCLES) * CLK_NS
                               + 2000;

  typedef enum logic [1:0] {VAR_FIXED, VAR_EXTREME, VAR_RANDOM} variant_e;

  typedef struct packed {
    logic [4:0] nodes;
    variant_e   variant;
    logic [5:0] exp_status;  // flag order as in dbg_status_t.
  } test_entry_t;

  logic        clk;
  logic        rst_n;
  logic        host_we;
  host_wr_t    host_wr;
  logic        run;
  node_idx_t   run_nodes;
  logic        busy;
  logic        done;
  logic        out_we;
  out_wr_t     out_wr;
  dbg_status_t dbg_status;
  logic [31:0] dbg_count;
  acc_t        cap_a;
  acc_t        cap_b;

  test_entry_t tests [NUM_TESTS];
  sp_addr_t    m_base [`GNN_NODES];
  nnz_t        m_nnz  [`GNN_NODES];
  node_idx_t   m_col  [2**`GNN_SP_AW];
  feat_t       m_val  [2**`GNN_SP_AW];
  feat_t       m_feat [`GNN_NODES];
  out_wr_t     got_q  [$];
  int          errors;
  int          test_errors;
  int          failed_tests;
  int          total_nodes;
  acc_t        exp_cap_a;
  acc_t        exp_cap_b;

  gnn_layer_top i_dut (
    .clk(clk), .rst_n(rst_n), .host_we_i(host_we), .host_wr_i(host_wr),
    .run_i(run), .run_nodes_i(run_nodes), .busy_o(busy), .done_o(done),
    .out_we_o(out_we), .out_wr_o(out_wr), .debug_status_o(dbg_status),
    .debug_count_o(dbg_count), .debug_capture_a_o(cap_a), .debug_capture_b_o(cap_b)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic host_write(input mem_sel_e sel, input logic [7:0] addr,
                            input logic [31:0] data);
    host_wr_t w;
    w.sel  = sel;
    w.addr = addr;
    w.data = data;
    @(posedge clk);
    host_we <= 1'b1;
    host_wr <= w;
  endtask

  // rows sit 16 entries apart, so no row overlaps the next.
  task automatic build_graph(input variant_e v);
    int nnz;
    int a;
    int col;
    int val;
    for (int n = 0; n < `GNN_NODES; n++) begin
      case (v)
        VAR_FIXED:   m_feat[n] = feat_t'(n * 23 - 150);
        VAR_EXTREME: m_feat[n] = (n == 15) ? -16'sd1 : 16'sd1;
        default:     m_feat[n] = feat_t'($urandom);
      endcase
    end
    for (int n = 0; n < `GNN_NODES; n++) begin
      case (v)
        VAR_FIXED:   nnz = (n * 5) % (`GNN_MAX_NNZ + 1);
        VAR_EXTREME: nnz = (n % 4 == 2) ? 0 : ((n % 4 == 3) ? 2 : `GNN_MAX_NNZ);
        default:     nnz = $urandom % (`GNN_MAX_NNZ + 1);
      endcase
      m_base[n] = sp_addr_t'(n * 16);
      m_nnz[n]  = nnz_t'(nnz);
      for (int k = 0; k < nnz; k++) begin
        a = n * 16 + k;
        case (v)
          VAR_FIXED: begin
            col = (n + 3 * k) % `GNN_NODES;
            val = (n * 37 + k * 53) % 200 - 100;
          end
          VAR_EXTREME: begin
            // sums of 32767 exactly or one above it on the upper nodes.
            if (n % 4 == 3) begin
              col = (k == 0) ? 15 : 0;
              val = (k == 0) ? -32767 : ((n >= 8) ? 1 : 0);
            end else begin
              col = k;
              val = (n % 4 == 0) ? -30000 : 30000;
            end
          end
          default: begin
            col = $urandom % `GNN_NODES;
            val = $urandom;
          end
        endcase
        m_col[a] = node_idx_t'(col);
        m_val[a] = feat_t'(val);
      end
    end
  endtask

  task automatic load_graph();
    int a;
    for (int n = 0; n < `GNN_NODES; n++) begin
      host_write(MEM_INFO, 8'(n), 32'({m_base[n], m_nnz[n]}));
      host_write(MEM_FEAT, 8'(n), {16'h0000, m_feat[n]});
      for (int k = 0; k < int'(m_nnz[n]); k++) begin
        a = int'(m_base[n]) + k;
        host_write(MEM_SPARSE, 8'(a), 32'({m_col[a], m_val[a]}));
      end
    end
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  // dot product of one row with the features in 32 bit wrapping arithmetic.
  function automatic int node_sum(input int n);
    int s;
    int a;
    s = 0;
    for (int k = 0; k < int'(m_nnz[n]); k++) begin
      a = int'(m_base[n]) + k;
      s += int'(m_val[a]) * int'(m_feat[m_col[a]]);
    end
    return s;
  endfunction

  function automatic feat_t relu_sat(input int s);
    if (s < 0) return '0;
    if (s > 32767) return 16'sd32767;
    return feat_t'(s);
  endfunction

  task automatic check_reset_state();
    test_errors = 0;
    compare_value("out_we_o after reset", out_we, 0);
    compare_value("done_o after reset", done, 0);
    compare_value("busy_o after reset", busy, 0);
    compare_value("debug status after reset", dbg_status, 0);
    compare_value("debug count after reset", dbg_count, 0);
    compare_value("capture a after reset", cap_a, 0);
    compare_value("capture b after reset", cap_b, 0);
    $display("reset check: %s", (test_errors == 0) ? "ok" : "FAILED");
    if (test_errors != 0) failed_tests++;
  endtask

  task automatic run_test(input int t);
    int       n_nodes;
    int       cycles;
    bit       timed_out;
    variant_e v;
    n_nodes     = int'(tests[t].nodes);
    v           = tests[t].variant;
    test_errors = 0;
    build_graph(v);
    load_graph();
    got_q.delete();
    @(posedge clk);
    run       <= 1'b1;
    run_nodes <= node_idx_t'(n_nodes - 1);
    @(posedge clk);
    run <= 1'b0;
    @(negedge clk);
    compare_value("busy_o after run", busy, 1);
    cycles    = 0;
    timed_out = 0;
    while (!done && !timed_out) begin
      @(negedge clk);
      if (out_we) got_q.push_back(out_wr);
      cycles++;
      if (cycles > n_nodes * NODE_CYCLES + 8) timed_out = 1;
    end
    if (timed_out) begin
      $display("test %0d: done_o did not arrive within %0d cycles", t, cycles);
      errors++;
      test_errors++;
    end
    compare_value("write count", got_q.size(), n_nodes);
    for (int n = 0; n < n_nodes && n < got_q.size(); n++) begin
      compare_value($sformatf("node %0d address", n), got_q[n].addr, `GNN_OUT_BASE + n);
      compare_value($sformatf("node %0d data", n), got_q[n].data, relu_sat(node_sum(n)));
    end
    if (n_nodes > `GNN_DBG_CAPTURE_A) exp_cap_a = node_sum(`GNN_DBG_CAPTURE_A);
    if (n_nodes > `GNN_DBG_CAPTURE_B) exp_cap_b = node_sum(`GNN_DBG_CAPTURE_B);
    total_nodes += n_nodes;
    compare_value("busy_o after done", busy, 0);
    compare_value("debug count", dbg_count, total_nodes);
    compare_value("debug status", dbg_status, tests[t].exp_status);
    compare_value("capture a", cap_a, exp_cap_a);
    compare_value("capture b", cap_b, exp_cap_b);
    if (test_errors != 0) failed_tests++;
    $display("test %0d: %s graph, %0d nodes, %0d writes, %s", t, v.name(), n_nodes,
             got_q.size(), (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(9891));
    clk          = 1'b0;
    rst_n        = 1'b0;
    host_we      = 1'b0;
    host_wr      = '0;
    run          = 1'b0;
    run_nodes    = '0;
    errors       = 0;
    failed_tests = 0;
    total_nodes  = 0;
    exp_cap_a    = '0;
    exp_cap_b    = '0;
    // first run stays below the reserved region.
    tests[0] = '{5'd12, VAR_FIXED, 6'b111110};
    tests[1] = '{5'd16, VAR_EXTREME, 6'b111111};
    tests[2] = '{5'd8, VAR_RANDOM, 6'b111111};
    tests[3] = '{5'd16, VAR_RANDOM, 6'b111111};
    tests[4] = '{5'd5, VAR_RANDOM, 6'b111111};
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run %0d, tests failed %0d, mismatches %0d", NUM_TESTS + 1,
             failed_tests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
